// File: hdl/ciPackage.sv
`default_nettype none

package ciPackage;

  // Width of the operand and result words of the custom-instruction port
  localparam int DATA_WIDTH = 32;

  // Instruction numbers as seen on the port of the processor
  typedef enum logic [7:0] {
    SWAP_BYTE   = 8'h01,
    MICRO_DELAY = 8'h06,
    RGB_TO_GRAY = 8'h0D,
    ABS_DIFF    = 8'h32
  } ciOpcode_e;

  typedef enum logic [1:0] {
    SWAP,
    GRAY,
    ABSDIFF
  } pixelOp_e;

  typedef enum logic [1:0] {
    IDLE,
    ANSWER,
    DELAYING
  } ciState_e;

  // The opcode stays raw so that unknown instruction numbers can be represented
  typedef struct packed {
    logic                  start;
    logic [7:0]            opcode;
    logic [DATA_WIDTH-1:0] dataA;
    logic [DATA_WIDTH-1:0] dataB;
  } ciRequest_t;

  typedef struct packed {
    logic                  done;
    logic [DATA_WIDTH-1:0] result;
  } ciResponse_t;

endpackage

`default_nettype wire

// File: hdl/ciSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ciSequencer (
  input  logic                                 s_systemClock,
  input  logic                                 s_pllLocked,
  input  logic                                 systemReset,
  input  ciPackage::ciRequest_t                ciRequest,
  input  logic [ciPackage::DATA_WIDTH-1:0]     aluResult,
  input  logic                                 delayExpired,
  output ciPackage::pixelOp_e                  aluSelect,
  output logic [ciPackage::DATA_WIDTH-1:0]     operandA,
  output logic [ciPackage::DATA_WIDTH-1:0]     operandB,
  output logic                                 delayLoad,
  output logic [ciPackage::DATA_WIDTH-1:0]     delayMicroseconds,
  output ciPackage::ciResponse_t               ciResponse
);

  ciPackage::ciState_e  state;
  ciPackage::ciState_e  nextState;
  ciPackage::ciOpcode_e opcode;
  ciPackage::pixelOp_e  nextSelect;
  logic                 accept;
  logic                 zeroAnswer;
  logic                 nextZeroAnswer;

  assign opcode = ciPackage::ciOpcode_e'(ciRequest.opcode);
  assign accept = ciRequest.start && (state == ciPackage::IDLE);

  // A zero delay is answered like an ALU instruction and never starts the timer
  assign delayLoad = accept && (opcode == ciPackage::MICRO_DELAY) &&
                     (ciRequest.dataA != '0);
  assign delayMicroseconds = ciRequest.dataA;

  always_comb begin
    nextState      = state;
    nextSelect     = ciPackage::SWAP;
    nextZeroAnswer = 1'b0;
    case (state)
      ciPackage::IDLE: begin
        if (ciRequest.start) begin
          nextState = ciPackage::ANSWER;
          case (opcode)
            ciPackage::SWAP_BYTE:   nextSelect = ciPackage::SWAP;
            ciPackage::RGB_TO_GRAY: nextSelect = ciPackage::GRAY;
            ciPackage::ABS_DIFF:    nextSelect = ciPackage::ABSDIFF;
            ciPackage::MICRO_DELAY: begin
              nextZeroAnswer = 1'b1;
              if (delayLoad) begin
                nextState = ciPackage::DELAYING;
              end
            end
            default: nextZeroAnswer = 1'b1;
          endcase
        end
      end
      ciPackage::ANSWER: nextState = ciPackage::IDLE;
      ciPackage::DELAYING: begin
        nextZeroAnswer = 1'b1;
        if (delayExpired) begin
          nextState = ciPackage::ANSWER;
        end
      end
      default: nextState = ciPackage::IDLE;
    endcase
  end

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      state      <= ciPackage::IDLE;
      zeroAnswer <= 1'b0;
    end else if (systemReset) begin
      state      <= ciPackage::IDLE;
      zeroAnswer <= 1'b0;
    end else begin
      state      <= nextState;
      zeroAnswer <= nextZeroAnswer;
    end
  end

  // Operands of the accepted request feed the ALU while the answer is shown
  always_ff @(posedge s_systemClock) begin
    if (accept) begin
      operandA  <= ciRequest.dataA;
      operandB  <= ciRequest.dataB;
      aluSelect <= nextSelect;
    end
  end

  assign ciResponse.done   = (state == ciPackage::ANSWER);
  assign ciResponse.result = (ciResponse.done && !zeroAnswer) ? aluResult : '0;

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked || systemReset)
    ciRequest.start |-> state == ciPackage::IDLE)
    else $error("start received while an instruction is still running");

endmodule

`default_nettype wire

// File: hdl/customInstructionUnit.sv
`timescale 1ns/1ps
`default_nettype none

module customInstructionUnit #(
  parameter int CLOCK_FREQUENCY_HZ = 74250000,
  parameter int RESET_CYCLES       = 16
) (
  input  logic                   s_systemClock,
  input  logic                   s_pllLocked,
  input  ciPackage::ciRequest_t  ciRequest,
  output ciPackage::ciResponse_t ciResponse,
  output logic                   peripheralResetN
);

  logic                             systemReset;
  logic                             delayLoad;
  logic                             delayExpired;
  logic [ciPackage::DATA_WIDTH-1:0] delayMicroseconds;
  logic [ciPackage::DATA_WIDTH-1:0] operandA;
  logic [ciPackage::DATA_WIDTH-1:0] operandB;
  logic [ciPackage::DATA_WIDTH-1:0] aluResult;
  ciPackage::pixelOp_e              aluSelect;

  resetSequencer #(
    .RESET_CYCLES(RESET_CYCLES)
  ) resetSequencer_inst (
    .s_systemClock   (s_systemClock),
    .s_pllLocked     (s_pllLocked),
    .systemReset     (systemReset),
    .peripheralResetN(peripheralResetN)
  );

  ciSequencer ciSequencer_inst (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .systemReset      (systemReset),
    .ciRequest        (ciRequest),
    .aluResult        (aluResult),
    .delayExpired     (delayExpired),
    .aluSelect        (aluSelect),
    .operandA         (operandA),
    .operandB         (operandB),
    .delayLoad        (delayLoad),
    .delayMicroseconds(delayMicroseconds),
    .ciResponse       (ciResponse)
  );

  delayTimer #(
    .CLOCK_FREQUENCY_HZ(CLOCK_FREQUENCY_HZ)
  ) delayTimer_inst (
    .s_systemClock    (s_systemClock),
    .s_pllLocked      (s_pllLocked),
    .systemReset      (systemReset),
    .delayLoad        (delayLoad),
    .delayMicroseconds(delayMicroseconds),
    .delayExpired     (delayExpired)
  );

  pixelAlu pixelAlu_inst (
    .aluSelect(aluSelect),
    .operandA (operandA),
    .operandB (operandB),
    .aluResult(aluResult)
  );

endmodule

`default_nettype wire

// File: hdl/delayTimer.sv
`timescale 1ns/1ps
`default_nettype none

module delayTimer #(
  parameter int CLOCK_FREQUENCY_HZ = 74250000
) (
  input  logic                             s_systemClock,
  input  logic                             s_pllLocked,
  input  logic                             systemReset,
  input  logic                             delayLoad,
  input  logic [ciPackage::DATA_WIDTH-1:0] delayMicroseconds,
  output logic                             delayExpired
);

  localparam int TICKS_PER_MICROSECOND = CLOCK_FREQUENCY_HZ / 1000000;
  localparam int PRESCALE_WIDTH = $clog2(TICKS_PER_MICROSECOND + 1);
  localparam logic [PRESCALE_WIDTH-1:0] LAST_TICK = PRESCALE_WIDTH'(TICKS_PER_MICROSECOND - 1);

  logic [PRESCALE_WIDTH-1:0]        prescaler;
  logic [ciPackage::DATA_WIDTH-1:0] microsecondsLeft;
  logic                             counting;
  logic                             microsecondTick;

  assign microsecondTick = (prescaler == LAST_TICK);

  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      counting         <= 1'b0;
      prescaler        <= '0;
      microsecondsLeft <= '0;
    end else if (systemReset) begin
      counting         <= 1'b0;
      prescaler        <= '0;
      microsecondsLeft <= '0;
    end else if (delayLoad) begin
      counting         <= 1'b1;
      prescaler        <= '0;
      microsecondsLeft <= delayMicroseconds;
    end else if (counting) begin
      if (microsecondTick) begin
        prescaler        <= '0;
        microsecondsLeft <= microsecondsLeft - 1'b1;
        if (microsecondsLeft == 1) begin
          counting <= 1'b0;
        end
      end else begin
        prescaler <= prescaler + 1'b1;
      end
    end
  end

  // Last tick of the last microsecond
  assign delayExpired = counting && microsecondTick && (microsecondsLeft == 1);

  assert property (@(posedge s_systemClock) disable iff (!s_pllLocked || systemReset)
    delayLoad |-> !counting)
    else $error("delay loaded while the timer is still counting");

endmodule

`default_nettype wire

// File: hdl/pixelAlu.sv
`timescale 1ns/1ps
`default_nettype none

module pixelAlu (
  input  ciPackage::pixelOp_e              aluSelect,
  input  logic [ciPackage::DATA_WIDTH-1:0] operandA,
  input  logic [ciPackage::DATA_WIDTH-1:0] operandB,
  output logic [ciPackage::DATA_WIDTH-1:0] aluResult
);

  localparam int LANES = ciPackage::DATA_WIDTH / 8;

  logic [ciPackage::DATA_WIDTH-1:0] swapResult;
  logic [ciPackage::DATA_WIDTH-1:0] grayResult;
  logic [ciPackage::DATA_WIDTH-1:0] absDiffResult;
  logic [15:0]                      redLevel;
  logic [15:0]                      greenLevel;
  logic [15:0]                      blueLevel;
  logic [15:0]                      weightedSum;

  for (genvar lane = 0; lane < LANES; lane++) begin : gen_lane
    logic [7:0] laneA;
    logic [7:0] laneB;

    assign laneA = operandA[8*lane +: 8];
    assign laneB = operandB[8*lane +: 8];

    // Byte order reversed across the whole word
    assign swapResult[8*lane +: 8] = operandA[ciPackage::DATA_WIDTH-8*(lane+1) +: 8];

    assign absDiffResult[8*lane +: 8] = (laneA >= laneB) ? laneA - laneB : laneB - laneA;
  end

  // RGB565 in the low half word, each channel widened to 8 bits
  assign redLevel   = {8'd0, operandA[15:11], 3'd0};
  assign greenLevel = {8'd0, operandA[10:5], 2'd0};
  assign blueLevel  = {8'd0, operandA[4:0], 3'd0};

  // Weights add up to 256, so the sum never leaves 16 bits
  assign weightedSum = 16'd77 * redLevel + 16'd150 * greenLevel + 16'd29 * blueLevel;
  assign grayResult  = {{(ciPackage::DATA_WIDTH-8){1'b0}}, weightedSum[15:8]};

  always_comb begin
    case (aluSelect)
      ciPackage::SWAP:    aluResult = swapResult;
      ciPackage::GRAY:    aluResult = grayResult;
      ciPackage::ABSDIFF: aluResult = absDiffResult;
      default:            aluResult = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/resetSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module resetSequencer #(
  parameter int RESET_CYCLES = 16
) (
  input  logic s_systemClock,
  input  logic s_pllLocked,
  output logic systemReset,
  output logic peripheralResetN
);

  localparam int COUNT_WIDTH = $clog2(RESET_CYCLES + 1);
  localparam logic [COUNT_WIDTH-1:0] LAST_COUNT = COUNT_WIDTH'(RESET_CYCLES);

  logic [COUNT_WIDTH-1:0] lockCount;
  logic                   released;

  assign released = (lockCount == LAST_COUNT);

  // Restarts from zero every time the PLL drops lock, then saturates
  always_ff @(posedge s_systemClock or negedge s_pllLocked) begin
    if (!s_pllLocked) begin
      lockCount <= '0;
    end else if (!released) begin
      lockCount <= lockCount + 1'b1;
    end
  end

  assign systemReset      = ~released;
  assign peripheralResetN = released;

endmodule

`default_nettype wire

// File: runSim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for the fail message

LOG=sim.log

rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbCustomInstructionUnit -f verilog.f -o tbSim > "$LOG" 2>&1 \
  && ./obj_dir/tbSim >> "$LOG" 2>&1 \
  || echo "TESTBENCH FAILED" >> "$LOG"

cat "$LOG"

grep -q "TESTBENCH FAILED" "$LOG" && { echo "Simulation failed, see $LOG"; exit 1; }
grep -q "TESTBENCH PASSED" "$LOG" || { echo "Simulation ended without a result"; exit 1; }

echo "Simulation passed"
exit 0

// File: include/ciReferenceModel.svh
`ifndef CI_REFERENCE_MODEL_SVH
`define CI_REFERENCE_MODEL_SVH

// Classic 32-bit xorshift with shifts 13, 17 and 5
function automatic logic [31:0] xorshift32(input logic [31:0] state);
  logic [31:0] x;
  x = state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] reverseBytes(input logic [31:0] word);
  return {word[7:0], word[15:8], word[23:16], word[31:24]};
endfunction

// RGB565 in the low half word, red and blue scaled by 8 and green by 4
function automatic logic [31:0] rgb565ToGray(input logic [31:0] word);
  int red;
  int green;
  int blue;
  int sum;
  red   = int'(word[15:11]) * 8;
  green = int'(word[10:5]) * 4;
  blue  = int'(word[4:0]) * 8;
  sum   = 77 * red + 150 * green + 29 * blue;
  return 32'(sum / 256);
endfunction

function automatic logic [31:0] byteAbsDifference(input logic [31:0] a, input logic [31:0] b);
  logic [31:0] diff;
  int          x;
  int          y;
  diff = '0;
  for (int lane = 0; lane < 4; lane++) begin
    x = int'(a[8*lane +: 8]);
    y = int'(b[8*lane +: 8]);
    diff[8*lane +: 8] = 8'((x > y) ? x - y : y - x);
  end
  return diff;
endfunction

function automatic bit isKnownOpcode(input logic [7:0] opcode);
  return opcode == 8'h01 || opcode == 8'h06 || opcode == 8'h0D || opcode == 8'h32;
endfunction

// Delays and unknown numbers answer with zero
function automatic logic [31:0] expectedResult(input logic [7:0] opcode,
                                               input logic [31:0] dataA,
                                               input logic [31:0] dataB);
  case (opcode)
    8'h01:   return reverseBytes(dataA);
    8'h0D:   return rgb565ToGray(dataA);
    8'h32:   return byteAbsDifference(dataA, dataB);
    default: return '0;
  endcase
endfunction

// Cycles from the start cycle to the done cycle
function automatic int expectedLatency(input logic [7:0] opcode, input logic [31:0] dataA,
                                       input int ticksPerMicrosecond);
  if (opcode == 8'h06 && dataA != '0) begin
    return int'(dataA) * ticksPerMicrosecond + 1;
  end
  return 1;
endfunction

`endif

// File: test/tbCustomInstructionUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tbCustomInstructionUnit;

  localparam int CLOCK_FREQUENCY_HZ    = 4000000;
  localparam int RESET_CYCLES          = 16;
  localparam int TICKS_PER_MICROSECOND = CLOCK_FREQUENCY_HZ / 1000000;
  localparam int DONE_TIMEOUT_CYCLES   = 200;
  localparam int RELEASE_TIMEOUT       = 64;
  localparam int ALU_REQUESTS          = 200;
  localparam int DELAY_REQUESTS        = 30;
  localparam int UNKNOWN_REQUESTS      = 50;

  logic                   s_systemClock;
  logic                   s_pllLocked;
  ciPackage::ciRequest_t  ciRequest;
  ciPackage::ciResponse_t ciResponse;
  logic                   peripheralResetN;

  logic [31:0] randomState;
  int          errorCount;
  int          errorsAtTestStart;
  int          testsPassed;
  int          testsFailed;

  `include "ciReferenceModel.svh"

  customInstructionUnit #(
    .CLOCK_FREQUENCY_HZ(CLOCK_FREQUENCY_HZ),
    .RESET_CYCLES      (RESET_CYCLES)
  ) customInstructionUnit_inst (
    .s_systemClock   (s_systemClock),
    .s_pllLocked     (s_pllLocked),
    .ciRequest       (ciRequest),
    .ciResponse      (ciResponse),
    .peripheralResetN(peripheralResetN)
  );

  always #10 s_systemClock = ~s_systemClock;

  function automatic logic [31:0] drawRandom();
    randomState = xorshift32(randomState);
    return randomState;
  endfunction

  function automatic logic [7:0] aluOpcodeFor(input logic [31:0] word);
    case (word % 3)
      0:       return 8'h01;
      1:       return 8'h0D;
      default: return 8'h32;
    endcase
  endfunction

  task automatic stopOnTimeout(input string reason);
    errorCount++;
    $display("Timeout at time %0t: %s", $time, reason);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic finishTest(input string name);
    int errors;
    errors = errorCount - errorsAtTestStart;
    if (errors == 0) begin
      testsPassed++;
      $display("Test %s: passed", name);
    end else begin
      testsFailed++;
      $display("Test %s: failed with %0d errors", name, errors);
    end
    errorsAtTestStart = errorCount;
  endtask

  // One request with a start pulse, then a bounded wait for done
  task automatic runAndCheck(input logic [7:0] opcode, input logic [31:0] dataA,
                             input logic [31:0] dataB);
    int          cycles;
    int          wantCycles;
    logic [31:0] wantResult;
    logic [31:0] gotResult;
    bit          answered;
    wantCycles = expectedLatency(opcode, dataA, TICKS_PER_MICROSECOND);
    wantResult = expectedResult(opcode, dataA, dataB);
    cycles     = 0;
    answered   = 1'b0;
    gotResult  = '0;
    @(posedge s_systemClock);
    #2;
    ciRequest.start  = 1'b1;
    ciRequest.opcode = opcode;
    ciRequest.dataA  = dataA;
    ciRequest.dataB  = dataB;
    while (!answered && cycles < DONE_TIMEOUT_CYCLES) begin
      @(posedge s_systemClock);
      #2;
      cycles++;
      if (ciResponse.done) begin
        answered  = 1'b1;
        gotResult = ciResponse.result;
      end else if (ciResponse.result != '0) begin
        $display("FAILED at time %0t: result %h while done is low, opcode %h",
                 $time, ciResponse.result, opcode);
        errorCount++;
      end
      ciRequest.start = 1'b0;
    end
    if (!answered) begin
      stopOnTimeout($sformatf("no done for opcode %h within %0d cycles",
                              opcode, DONE_TIMEOUT_CYCLES));
    end else begin
      if (cycles != wantCycles) begin
        $display("FAILED at time %0t: opcode %h dataA %h done after %0d cycles, expected %0d",
                 $time, opcode, dataA, cycles, wantCycles);
        errorCount++;
      end
      if (gotResult !== wantResult) begin
        $display("FAILED at time %0t: opcode %h dataA %h dataB %h gave %h, expected %h",
                 $time, opcode, dataA, dataB, gotResult, wantResult);
        errorCount++;
      end
    end
  endtask

  initial begin
    logic [31:0] dataA;
    logic [31:0] dataB;
    logic [31:0] word;
    logic [7:0]  opcode;
    int          edges;
    bit          released;
    s_systemClock     = 1'b0;
    s_pllLocked       = 1'b0;
    randomState       = 32'h3300_a02d;
    errorCount        = 0;
    errorsAtTestStart = 0;
    testsPassed       = 0;
    testsFailed       = 0;
    // A request held during reset must be ignored
    ciRequest         = '0;
    ciRequest.start   = 1'b1;
    ciRequest.opcode  = 8'h01;
    ciRequest.dataA   = 32'h1234_5678;

    repeat (10) begin
      @(posedge s_systemClock);
      #2;
      if (ciResponse.done || peripheralResetN) begin
        $display("FAILED at time %0t: done or peripheral reset release before lock", $time);
        errorCount++;
      end
    end
    s_pllLocked = 1'b1;
    edges       = 0;
    released    = 1'b0;
    while (!released && edges < RELEASE_TIMEOUT) begin
      @(posedge s_systemClock);
      #2;
      edges++;
      if (ciResponse.done) begin
        $display("FAILED at time %0t: done high during reset", $time);
        errorCount++;
      end
      released = peripheralResetN;
      if (edges == 8) begin
        ciRequest.start = 1'b0;
      end
    end
    if (!released) begin
      stopOnTimeout("peripheral reset never released after lock");
    end else if (edges != RESET_CYCLES) begin
      $display("FAILED at time %0t: reset released after %0d edges, expected %0d",
               $time, edges, RESET_CYCLES);
      errorCount++;
    end
    repeat (3) begin
      @(posedge s_systemClock);
      #2;
      if (ciResponse.done) begin
        $display("FAILED at time %0t: done high after release without a request", $time);
        errorCount++;
      end
    end
    finishTest("reset release");

    for (int i = 0; i < ALU_REQUESTS; i++) begin
      dataA = drawRandom();
      dataB = drawRandom();
      runAndCheck(8'h01, dataA, dataB);
    end
    finishTest("byte swap");

    for (int i = 0; i < ALU_REQUESTS; i++) begin
      word  = drawRandom();
      dataA = drawRandom();
      dataB = drawRandom();
      runAndCheck(word[0] ? 8'h0D : 8'h32, dataA, dataB);
    end
    finishTest("grayscale and absolute difference");

    for (int i = 0; i < DELAY_REQUESTS; i++) begin
      word  = drawRandom();
      dataB = drawRandom();
      runAndCheck(8'h06, {28'd0, word[3:0]}, dataB);
    end
    finishTest("microsecond delay");

    for (int i = 0; i < UNKNOWN_REQUESTS; i++) begin
      word   = drawRandom();
      opcode = word[7:0];
      while (isKnownOpcode(opcode)) begin
        opcode = opcode + 8'd1;
      end
      dataA = drawRandom();
      dataB = drawRandom();
      runAndCheck(opcode, dataA, dataB);
      word  = drawRandom();
      dataA = drawRandom();
      dataB = drawRandom();
      runAndCheck(aluOpcodeFor(word), dataA, dataB);
    end
    finishTest("unknown instruction numbers");

    $display("Tests run: %0d, passed: %0d, failed: %0d, errors: %0d",
             testsPassed + testsFailed, testsPassed, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
hdl/ciPackage.sv
hdl/resetSequencer.sv
hdl/delayTimer.sv
hdl/pixelAlu.sv
hdl/ciSequencer.sv
hdl/customInstructionUnit.sv
test/tbCustomInstructionUnit.sv
